// ==== Makefile ====
TOP := mem_island_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)

// ==== compile.f ====
hdl/mem_island_pkg.sv
hdl/bank_req_if.sv
hdl/bank_slice.sv
hdl/narrow_router.sv
hdl/wide_splitter.sv
hdl/mem_island_top.sv
dv/tb_clk_rst.sv
dv/mem_island_assertions.sv
dv/mem_island_tb.sv

// ==== dv/mem_island_assertions.sv ====
// Memory island checker
// Shadow memory of lane words plus concurrent checks on latency, priority and data

`timescale 1ns/100ps

module mem_island_assertions
  import mem_island_pkg::*;
#(
  parameter int unsigned NumWideBanks = 2,
  parameter int unsigned WordsPerBank = 256
) (
  input logic         clk_i,
  input logic         rst_ni,
  input logic         narrow_req_i,
  input addr_t        narrow_addr_i,
  input logic         narrow_we_i,
  input narrow_data_t narrow_wdata_i,
  input narrow_strb_t narrow_strb_i,
  input logic         narrow_gnt_o,
  input logic         narrow_rvalid_o,
  input narrow_data_t narrow_rdata_o,
  input logic         wide_req_i,
  input addr_t        wide_addr_i,
  input logic         wide_we_i,
  input wide_data_t   wide_wdata_i,
  input wide_strb_t   wide_strb_i,
  input logic         wide_gnt_o,
  input logic         wide_rvalid_o,
  input wide_data_t   wide_rdata_o
);

  localparam int unsigned SliceBits = $clog2(NumWideBanks * NumLanes);
  localparam int unsigned IdxBits   = SliceBits + $clog2(WordsPerBank);

  int fail_count = 0;

  narrow_data_t        shadow [2**IdxBits];
  logic [IdxBits-1:0]  n_idx;
  logic [IdxBits-1:0]  w_idx [NumLanes];
  logic [NumLanes-1:0] take;
  logic [NumLanes-1:0] wacc_q;
  logic                exp_gnt;
  logic                rst_q;
  logic                n_req_q;
  logic                n_rd_q;
  logic                w_gnt_q;
  logic                w_rd_q;
  narrow_data_t        n_exp_q;
  wide_data_t          wexp_q;

  // Lane is the lowest field, so a word's flat index is addr[LaneBit +: IdxBits]
  always_comb begin
    n_idx = narrow_addr_i[LaneBit +: IdxBits];
    for (int l = 0; l < NumLanes; l++) begin
      w_idx[l] = (wide_addr_i[LaneBit +: IdxBits] & ~IdxBits'(NumLanes - 1)) | IdxBits'(l);
      take[l]  = wide_req_i && !wacc_q[l] &&
                 !(narrow_req_i && n_idx[SliceBits-1:0] == w_idx[l][SliceBits-1:0]);
    end
    exp_gnt = wide_req_i && (&(wacc_q | take));
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_q   <= 1'b0;
      wacc_q  <= '0;
      n_req_q <= 1'b0;
      n_rd_q  <= 1'b0;
      w_gnt_q <= 1'b0;
      w_rd_q  <= 1'b0;
    end else begin
      rst_q   <= 1'b1;
      n_req_q <= narrow_req_i;
      n_rd_q  <= narrow_req_i && !narrow_we_i;
      w_gnt_q <= wide_gnt_o;
      w_rd_q  <= wide_gnt_o && !wide_we_i;
      wacc_q  <= exp_gnt ? '0 : (wacc_q | take);
    end
  end

  // Snapshot at acceptance, then merge written bytes
  always_ff @(posedge clk_i) begin
    if (narrow_req_i) begin
      n_exp_q <= shadow[n_idx];
      for (int b = 0; b < 4; b++) begin
        if (narrow_we_i && narrow_strb_i[b]) shadow[n_idx][8*b +: 8] <= narrow_wdata_i[8*b +: 8];
      end
    end
    for (int l = 0; l < NumLanes; l++) begin
      if (take[l]) begin
        wexp_q[32*l +: 32] <= shadow[w_idx[l]];
        for (int b = 0; b < 4; b++) begin
          if (wide_we_i && wide_strb_i[4*l + b]) begin
            shadow[w_idx[l]][8*b +: 8] <= wide_wdata_i[32*l + 8*b +: 8];
          end
        end
      end
    end
  end

  a_narrow_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    narrow_req_i |-> narrow_gnt_o)
    else begin
      $error("MISMATCH narrow_gnt expected 1 actual %0b", narrow_gnt_o);
      fail_count++;
    end

  a_narrow_rvalid: assert property (@(posedge clk_i) narrow_rvalid_o == n_req_q)
    else begin
      $error("MISMATCH narrow_rvalid expected %0b actual %0b", n_req_q, narrow_rvalid_o);
      fail_count++;
    end

  a_narrow_rdata: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (narrow_rvalid_o && n_rd_q) |-> narrow_rdata_o == n_exp_q)
    else begin
      $error("MISMATCH narrow_rdata expected %h actual %h", n_exp_q, narrow_rdata_o);
      fail_count++;
    end

  a_wide_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni) wide_gnt_o == exp_gnt)
    else begin
      $error("MISMATCH wide_gnt expected %0b actual %0b", exp_gnt, wide_gnt_o);
      fail_count++;
    end

  a_wide_rvalid: assert property (@(posedge clk_i) wide_rvalid_o == w_gnt_q)
    else begin
      $error("MISMATCH wide_rvalid expected %0b actual %0b", w_gnt_q, wide_rvalid_o);
      fail_count++;
    end

  a_wide_rdata: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wide_rvalid_o && w_rd_q) |-> wide_rdata_o == wexp_q)
    else begin
      $error("MISMATCH wide_rdata expected %h actual %h", wexp_q, wide_rdata_o);
      fail_count++;
    end

  // Covers reset and the first cycle after its release
  a_reset_idle: assert property (@(posedge clk_i)
    !rst_q |-> !(narrow_rvalid_o || wide_rvalid_o || wide_gnt_o))
    else begin
      $error("MISMATCH reset_idle expected 000 actual %b%b%b",
             narrow_rvalid_o, wide_rvalid_o, wide_gnt_o);
      fail_count++;
    end

endmodule

bind mem_island_top mem_island_assertions #(
  .NumWideBanks ( NumWideBanks ),
  .WordsPerBank ( WordsPerBank )
) i_mem_island_assertions (
  .clk_i, .rst_ni,
  .narrow_req_i, .narrow_addr_i, .narrow_we_i, .narrow_wdata_i, .narrow_strb_i,
  .narrow_gnt_o, .narrow_rvalid_o, .narrow_rdata_o,
  .wide_req_i, .wide_addr_i, .wide_we_i, .wide_wdata_i, .wide_strb_i,
  .wide_gnt_o, .wide_rvalid_o, .wide_rdata_o
);

// ==== dv/mem_island_tb.sv ====
// Memory island testbench
// Random narrow and wide traffic on a small address window, checked by bound assertions

`timescale 1ns/100ps

module mem_island_tb
  import mem_island_pkg::*;
();

  localparam int NumTrans      = 400;
  localparam int TimeoutCycles = 3000;

  logic         clk;
  logic         rst_n;
  logic         narrow_req_i;
  addr_t        narrow_addr_i;
  logic         narrow_we_i;
  narrow_data_t narrow_wdata_i;
  narrow_strb_t narrow_strb_i;
  logic         narrow_gnt_o;
  logic         narrow_rvalid_o;
  narrow_data_t narrow_rdata_o;
  logic         wide_req_i;
  addr_t        wide_addr_i;
  logic         wide_we_i;
  wide_data_t   wide_wdata_i;
  wide_strb_t   wide_strb_i;
  logic         wide_gnt_o;
  logic         wide_rvalid_o;
  wide_data_t   wide_rdata_o;

  logic [31:0] seed = 32'h66f37e28;
  int          cycles = 0;

  tb_clk_rst u_clk_rst (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  mem_island_top DUT (
    .clk_i ( clk ),
    .rst_ni ( rst_n ),
    .narrow_req_i, .narrow_addr_i, .narrow_we_i, .narrow_wdata_i, .narrow_strb_i,
    .narrow_gnt_o, .narrow_rvalid_o, .narrow_rdata_o,
    .wide_req_i, .wide_addr_i, .wide_we_i, .wide_wdata_i, .wide_strb_i,
    .wide_gnt_o, .wide_rvalid_o, .wide_rdata_o
  );

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  initial begin
    int          n_sent;
    int          w_sent;
    int          n_run;
    logic        w_free;
    logic        done;
    logic [31:0] r;
    logic [31:0] d0;
    logic [31:0] d1;
    n_sent = 0;
    w_sent = 0;
    n_run  = 0;
    done   = 1'b0;
    narrow_req_i   = 1'b0;
    narrow_addr_i  = '0;
    narrow_we_i    = 1'b0;
    narrow_wdata_i = '0;
    narrow_strb_i  = '0;
    wide_req_i     = 1'b0;
    wide_addr_i    = '0;
    wide_we_i      = 1'b0;
    wide_wdata_i   = '0;
    wide_strb_i    = '0;
    wait (rst_n);
    // Fill the whole window so every later read has a known value
    for (int i = 0; i < 32; i++) begin
      @(posedge clk);
      narrow_req_i   <= 1'b1;
      narrow_we_i    <= 1'b1;
      narrow_addr_i  <= addr_t'(i) << 2;
      narrow_wdata_i <= next_rand();
      narrow_strb_i  <= 4'hf;
    end
    while (!done) begin
      @(posedge clk);
      w_free = !wide_req_i || wide_gnt_o;
      // Both ports are spent and the last wide request has been granted
      done   = w_free && w_sent >= NumTrans && n_sent >= NumTrans;
      if (w_free) begin
        r = next_rand();
        if (w_sent < NumTrans && r[1:0] != 2'b00) begin
          d0 = next_rand();
          d1 = next_rand();
          wide_req_i   <= 1'b1;
          wide_we_i    <= r[2];
          // High bits alias onto the same lines
          wide_addr_i  <= (r & 32'hffff_f000) | (next_rand() & 32'h78);
          wide_wdata_i <= {d1, d0};
          wide_strb_i  <= r[15:8];
          w_sent++;
        end else begin
          wide_req_i <= 1'b0;
        end
      end
      r = next_rand();
      if (n_sent < NumTrans && n_run < 3 && r[0]) begin
        narrow_req_i   <= 1'b1;
        narrow_we_i    <= r[1];
        narrow_addr_i  <= (r & 32'hffff_f000) | (next_rand() & 32'h7c);
        narrow_wdata_i <= next_rand();
        narrow_strb_i  <= r[7:4];
        n_run++;
        n_sent++;
      end else begin
        narrow_req_i <= 1'b0;
        n_run = 0;
      end
    end
    repeat (3) @(posedge clk);
    if (DUT.i_mem_island_assertions.fail_count == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("*** TEST FAILED ***");
      $fatal(1, "Checker reported failures");
    end
  end

  // Stop at the first failed assertion
  initial begin
    wait (DUT.i_mem_island_assertions.fail_count != 0);
    $display("*** TEST FAILED ***");
    $fatal(1, "An assertion in the checker failed");
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("*** TEST FAILED ***");
      $fatal(1, "Timeout, the run did not finish within %0d cycles", TimeoutCycles);
    end
  end

endmodule

// ==== dv/tb_clk_rst.sv ====
// Testbench clock and reset generator
// 10 ns clock, active-low reset held for the first 16 cycles

`timescale 1ns/100ps

module tb_clk_rst #(
  parameter int unsigned ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

  always #5 clk_o = ~clk_o;

endmodule

// ==== hdl/bank_req_if.sv ====
// Lane bank request interface
// One request/grant channel into a lane bank plus the read word coming back

`timescale 1ns/100ps

interface bank_req_if
  import mem_island_pkg::*;
#(
  parameter int unsigned WordsPerBank = 256
);

  localparam int unsigned WordAddrWidth = $clog2(WordsPerBank);

  logic                     req;
  logic                     we;
  logic [WordAddrWidth-1:0] addr;
  narrow_data_t             wdata;
  narrow_strb_t             strb;
  logic                     gnt;
  // Valid the cycle after acceptance
  narrow_data_t             rdata;

  modport requester (output req, we, addr, wdata, strb, input gnt, rdata);

  modport bank (input req, we, addr, wdata, strb, output gnt, rdata);

endinterface

// ==== hdl/bank_slice.sv ====
// Lane bank slice
// Narrow requests always win; wide requests only go through when the
// narrow side is idle. Byte-strobed single-port array, one cycle read latency

`timescale 1ns/100ps

module bank_slice
  import mem_island_pkg::*;
#(
  parameter int unsigned WordsPerBank = 256
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  bank_req_if.bank narrow_bus,
  bank_req_if.bank wide_bus
);

  localparam int unsigned WordAddrWidth = $clog2(WordsPerBank);

  logic                     mem_req;
  logic                     mem_we;
  logic [WordAddrWidth-1:0] mem_addr;
  narrow_data_t             mem_wdata;
  narrow_strb_t             mem_strb;
  narrow_data_t             rdata_q;

  narrow_data_t mem_q [WordsPerBank];

  // The narrow side never waits
  assign narrow_bus.gnt = 1'b1;
  assign wide_bus.gnt   = ~narrow_bus.req;

  assign mem_req = narrow_bus.req | wide_bus.req;

  always_comb begin
    if (narrow_bus.req) begin
      mem_we    = narrow_bus.we;
      mem_addr  = narrow_bus.addr;
      mem_wdata = narrow_bus.wdata;
      mem_strb  = narrow_bus.strb;
    end else begin
      mem_we    = wide_bus.we;
      mem_addr  = wide_bus.addr;
      mem_wdata = wide_bus.wdata;
      mem_strb  = wide_bus.strb;
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (mem_req && mem_we) begin
      for (int unsigned b = 0; b < NarrowStrbWidth; b++) begin
        if (mem_strb[b]) begin
          mem_q[mem_addr][8*b +: 8] <= mem_wdata[8*b +: 8];
        end
      end
    end
  end

  // Read port register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (mem_req && !mem_we) begin
      rdata_q <= mem_q[mem_addr];
    end
  end

  // Both requesters see the same word and only the accepted one uses it
  assign narrow_bus.rdata = rdata_q;
  assign wide_bus.rdata   = rdata_q;

endmodule

// ==== hdl/mem_island_pkg.sv ====
// Memory island shared definitions
// Data widths, address field positions and the common payload types

package mem_island_pkg;

  // Byte address width
  localparam int unsigned AddrWidth = 32;

  // Port data widths
  localparam int unsigned NarrowWidth = 32;
  localparam int unsigned WideWidth   = 64;

  // Byte enables per word
  localparam int unsigned NarrowStrbWidth = NarrowWidth / 8;
  localparam int unsigned WideStrbWidth   = WideWidth / 8;

  // Lane banks that together form one wide bank
  localparam int unsigned NumLanes = WideWidth / NarrowWidth;

  // Address fields from low to high are byte offset, lane, wide bank and word index
  localparam int unsigned LaneBit     = 2;
  localparam int unsigned WideBankBit = 3;

  typedef logic [AddrWidth-1:0] addr_t;

  typedef logic [NarrowWidth-1:0] narrow_data_t;

  typedef logic [NarrowStrbWidth-1:0] narrow_strb_t;

  // Lane 0 sits in the low half
  typedef logic [WideWidth-1:0] wide_data_t;

  typedef logic [WideStrbWidth-1:0] wide_strb_t;

endpackage

// ==== hdl/mem_island_top.sv ====
// Banked memory island
// One narrow 32-bit port and one wide 64-bit port sharing
// NumWideBanks x 2 lane banks, narrow accesses first

`timescale 1ns/100ps

module mem_island_top
  import mem_island_pkg::*;
#(
  parameter int unsigned NumWideBanks = 2,
  parameter int unsigned WordsPerBank = 256
) (
  input  logic         clk_i,
  input  logic         rst_ni,

  // Narrow port
  input  logic         narrow_req_i,
  input  addr_t        narrow_addr_i,
  input  logic         narrow_we_i,
  input  narrow_data_t narrow_wdata_i,
  input  narrow_strb_t narrow_strb_i,
  output logic         narrow_gnt_o,
  output logic         narrow_rvalid_o,
  output narrow_data_t narrow_rdata_o,

  // Wide port
  input  logic         wide_req_i,
  input  addr_t        wide_addr_i,
  input  logic         wide_we_i,
  input  wide_data_t   wide_wdata_i,
  input  wide_strb_t   wide_strb_i,
  output logic         wide_gnt_o,
  output logic         wide_rvalid_o,
  output wide_data_t   wide_rdata_o
);

  localparam int unsigned NumBanks = NumWideBanks * NumLanes;

  // Slice i serves wide bank i / NumLanes, lane i % NumLanes
  bank_req_if #(.WordsPerBank(WordsPerBank)) narrow_bus [NumBanks] ();
  bank_req_if #(.WordsPerBank(WordsPerBank)) wide_bus   [NumBanks] ();

  narrow_router #(
    .NumWideBanks ( NumWideBanks ),
    .WordsPerBank ( WordsPerBank )
  ) i_narrow_router (
    .clk_i,
    .rst_ni,
    .req_i    ( narrow_req_i    ),
    .addr_i   ( narrow_addr_i   ),
    .we_i     ( narrow_we_i     ),
    .wdata_i  ( narrow_wdata_i  ),
    .strb_i   ( narrow_strb_i   ),
    .gnt_o    ( narrow_gnt_o    ),
    .rvalid_o ( narrow_rvalid_o ),
    .rdata_o  ( narrow_rdata_o  ),
    .bank_bus ( narrow_bus      )
  );

  wide_splitter #(
    .NumWideBanks ( NumWideBanks ),
    .WordsPerBank ( WordsPerBank )
  ) i_wide_splitter (
    .clk_i,
    .rst_ni,
    .req_i    ( wide_req_i    ),
    .addr_i   ( wide_addr_i   ),
    .we_i     ( wide_we_i     ),
    .wdata_i  ( wide_wdata_i  ),
    .strb_i   ( wide_strb_i   ),
    .gnt_o    ( wide_gnt_o    ),
    .rvalid_o ( wide_rvalid_o ),
    .rdata_o  ( wide_rdata_o  ),
    .bank_bus ( wide_bus      )
  );

  for (genvar i = 0; i < NumBanks; i++) begin : gen_slice
    bank_slice #(
      .WordsPerBank ( WordsPerBank )
    ) i_bank_slice (
      .clk_i,
      .rst_ni,
      .narrow_bus ( narrow_bus[i] ),
      .wide_bus   ( wide_bus[i]   )
    );
  end

endmodule

// ==== hdl/narrow_router.sv ====
// Narrow port router
// Steers each narrow access to its lane bank with no added delay and
// returns the addressed bank's word one cycle later

`timescale 1ns/100ps

module narrow_router
  import mem_island_pkg::*;
#(
  parameter int unsigned NumWideBanks = 2,
  parameter int unsigned WordsPerBank = 256
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  addr_t                addr_i,
  input  logic                 we_i,
  input  narrow_data_t         wdata_i,
  input  narrow_strb_t         strb_i,
  output logic                 gnt_o,
  output logic                 rvalid_o,
  output narrow_data_t         rdata_o,
  bank_req_if.requester        bank_bus [NumWideBanks*NumLanes]
);

  localparam int unsigned NumBanks      = NumWideBanks * NumLanes;
  localparam int unsigned IdxWidth      = $clog2(NumBanks);
  localparam int unsigned WordAddrWidth = $clog2(WordsPerBank);
  localparam int unsigned WordBit       = WideBankBit + $clog2(NumWideBanks);

  logic [IdxWidth-1:0]      bank_idx;
  logic [IdxWidth-1:0]      bank_idx_q;
  logic [WordAddrWidth-1:0] word_idx;
  logic [NumBanks-1:0]      bank_gnt;
  logic                     rvalid_q;

  narrow_data_t bank_rdata [NumBanks];

  // Lane and wide-bank fields are adjacent, so together they give the
  // flat slice index wide_bank * NumLanes + lane
  assign bank_idx = addr_i[LaneBit +: IdxWidth];
  assign word_idx = addr_i[WordBit +: WordAddrWidth];

  for (genvar i = 0; i < NumBanks; i++) begin : gen_bank
    assign bank_bus[i].req   = req_i && (bank_idx == IdxWidth'(i));
    assign bank_bus[i].we    = we_i;
    assign bank_bus[i].addr  = word_idx;
    assign bank_bus[i].wdata = wdata_i;
    assign bank_bus[i].strb  = strb_i;
    assign bank_gnt[i]       = bank_bus[i].gnt;
    assign bank_rdata[i]     = bank_bus[i].rdata;
  end

  assign gnt_o = bank_gnt[bank_idx];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q   <= 1'b0;
      bank_idx_q <= '0;
    end else begin
      rvalid_q <= req_i && gnt_o;
      if (req_i) begin
        bank_idx_q <= bank_idx;
      end
    end
  end

  // Writes get a response too
  assign rvalid_o = rvalid_q;
  assign rdata_o  = bank_rdata[bank_idx_q];

endmodule

// ==== hdl/wide_splitter.sv ====
// Wide port splitter
// Splits a wide access over the two lanes of its wide bank, waits for
// every lane grant and assembles the wide read word

`timescale 1ns/100ps

module wide_splitter
  import mem_island_pkg::*;
#(
  parameter int unsigned NumWideBanks = 2,
  parameter int unsigned WordsPerBank = 256
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  addr_t                addr_i,
  input  logic                 we_i,
  input  wide_data_t           wdata_i,
  input  wide_strb_t           strb_i,
  output logic                 gnt_o,
  output logic                 rvalid_o,
  output wide_data_t           rdata_o,
  bank_req_if.requester        bank_bus [NumWideBanks*NumLanes]
);

  localparam int unsigned NumBanks      = NumWideBanks * NumLanes;
  localparam int unsigned SelWidth      = (NumWideBanks > 1) ? $clog2(NumWideBanks) : 1;
  localparam int unsigned WordAddrWidth = $clog2(WordsPerBank);
  localparam int unsigned WordBit       = WideBankBit + $clog2(NumWideBanks);

  logic [SelWidth-1:0]      wbank_sel;
  logic [SelWidth-1:0]      take_bank_q;
  logic [WordAddrWidth-1:0] word_idx;
  logic [NumBanks-1:0]      bank_gnt;
  logic [NumLanes-1:0]      lane_gnt;
  logic [NumLanes-1:0]      lane_take;
  logic [NumLanes-1:0]      lane_done;
  logic [NumLanes-1:0]      acc_q;
  logic [NumLanes-1:0]      rcap_q;
  logic                     rvalid_q;
  wide_data_t               rdata_q;

  narrow_data_t bank_rdata [NumBanks];

  // Masking keeps a single wide bank working without a select field
  assign wbank_sel = SelWidth'(addr_i >> WideBankBit) & SelWidth'(NumWideBanks - 1);
  assign word_idx  = addr_i[WordBit +: WordAddrWidth];

  for (genvar i = 0; i < NumBanks; i++) begin : gen_bank
    localparam int unsigned Lane = i % NumLanes;

    assign bank_bus[i].req   = req_i && !acc_q[Lane] &&
                               (wbank_sel == SelWidth'(i / NumLanes));
    assign bank_bus[i].we    = we_i;
    assign bank_bus[i].addr  = word_idx;
    assign bank_bus[i].wdata = wdata_i[NarrowWidth*Lane +: NarrowWidth];
    assign bank_bus[i].strb  = strb_i[NarrowStrbWidth*Lane +: NarrowStrbWidth];
    assign bank_gnt[i]       = bank_bus[i].gnt;
    assign bank_rdata[i]     = bank_bus[i].rdata;
  end

  always_comb begin
    for (int unsigned l = 0; l < NumLanes; l++) begin
      lane_gnt[l] = bank_gnt[wbank_sel*NumLanes + l];
    end
  end

  // A lane is taken only once per request
  assign lane_take = {NumLanes{req_i}} & ~acc_q & lane_gnt;
  assign lane_done = acc_q | lane_take;
  assign gnt_o     = req_i && (&lane_done);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q       <= '0;
      rcap_q      <= '0;
      rvalid_q    <= 1'b0;
      take_bank_q <= '0;
    end else begin
      if (gnt_o) begin
        acc_q <= '0;
      end else if (req_i) begin
        acc_q <= lane_done;
      end
      rcap_q   <= lane_take;
      rvalid_q <= gnt_o;
      if (|lane_take) begin
        take_bank_q <= wbank_sel;
      end
    end
  end

  // Hold lanes that were read ahead of the final grant
  always_ff @(posedge clk_i) begin
    for (int unsigned l = 0; l < NumLanes; l++) begin
      if (rcap_q[l]) begin
        rdata_q[NarrowWidth*l +: NarrowWidth] <= bank_rdata[take_bank_q*NumLanes + l];
      end
    end
  end

  // Lanes taken in the grant cycle come straight from the bank
  always_comb begin
    for (int unsigned l = 0; l < NumLanes; l++) begin
      if (rcap_q[l]) begin
        rdata_o[NarrowWidth*l +: NarrowWidth] = bank_rdata[take_bank_q*NumLanes + l];
      end else begin
        rdata_o[NarrowWidth*l +: NarrowWidth] = rdata_q[NarrowWidth*l +: NarrowWidth];
      end
    end
  end

  assign rvalid_o = rvalid_q;

endmodule
